/* testbench/rename_stimulus.txt */
# inputs: inst_en inst wb_en wb_tag wb_data clr | expected: disp_en rs1_val rs1_tag rs2_val
# rs2_tag rd op imm pc tag | issue_rdy commit_en commit_rd commit_data; hex, one line per cycle
1 00500093 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 0 0 0
1 00108133 0 0 0 0  1 0 0 0 0 1 0 5 0 1  1 0 0 0
1 ffc12183 0 0 0 0  1 0 1 0 1 2 0 0 4 2  1 0 0 0
1 0030a423 0 0 0 0  1 0 2 0 0 3 2 fffffffc 8 3  1 0 0 0
1 00010863 0 0 0 0  1 0 1 0 3 8 3 8 c 4  1 0 0 0
1 12345237 0 0 0 0  1 0 2 0 0 10 4 10 10 5  1 0 0 0
1 008002ef 0 0 0 0  1 0 0 0 3 4 1 12345000 14 6  1 0 0 0
1 00108093 0 0 0 0  1 0 0 0 0 5 5 8 18 7  1 0 0 0
1 00208333 0 0 0 0  1 0 1 0 1 1 0 1 1c 8  1 0 0 0
0 0 1 8 6 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 7 1c 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 6 12345000 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 5 0 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 4 0 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 3 11 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 2 a 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 1 1 5 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 1 5
1 003083b3 0 0 0 0  1 5 8 0 2 6 0 0 20 1  1 1 2 a
0 0 0 0 0 0  1 5 8 0 3 7 0 0 24 2  1 1 3 11
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 8 0
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 10 0
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 4 12345000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 5 1c
1 004084b3 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 1 6
0 0 1 1 77 0  1 6 0 12345000 0 9 0 0 28 3  1 0 0 0
0 0 0 0 0 1  0 0 0 0 0 0 0 0 0 0  1 1 6 77
1 00930533 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 0 0 0
0 0 0 0 0 0  1 77 0 0 0 a 0 0 0 1  1 0 0 0

/* rename_core.f */
rtl/rename_pkg.sv
rtl/inst_decoder.sv
rtl/tag_regfile.sv
rtl/reorder_buffer.sv
rtl/rename_core.sv
testbench/rename_core_sva.sv
testbench/rename_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rename_core.f --top-module rename_core_tb -o sim_rename
./obj_dir/sim_rename | tee sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/rename_core_tb.sv */
`default_nettype none

module rename_core_tb;

    logic                  clk;
    logic                  rst;
    logic                  clr;
    logic                  inst_en;
    rename_pkg::inst_t     inst;
    logic                  wb_en;
    rename_pkg::tag_t      wb_tag;
    rename_pkg::data_t     wb_data;
    logic                  issue_rdy;
    logic                  disp_en;
    rename_pkg::data_t     disp_rs1_val;
    rename_pkg::tag_t      disp_rs1_tag;
    rename_pkg::data_t     disp_rs2_val;
    rename_pkg::tag_t      disp_rs2_tag;
    rename_pkg::reg_name_t disp_rd;
    rename_pkg::op_class_t disp_op;
    rename_pkg::data_t     disp_imm;
    rename_pkg::addr_t     disp_pc;
    rename_pkg::tag_t      disp_tag;
    logic                  commit_en;
    rename_pkg::reg_name_t commit_rd;
    rename_pkg::data_t     commit_data;

    logic [31:0] fld [20];  // One stimulus line, columns in file order
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;

    rename_core dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name,
                             input logic [31:0] got,
                             input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            mismatches++;
            $display("error %s expected %h got %h", name, want, got);
        end
    endtask

    task automatic compare_outputs();
        check_val("issue_rdy", 32'(issue_rdy), fld[16]);
        check_val("disp_en", 32'(disp_en), fld[6]);
        if (fld[6][0]) begin  // Payload only matters while dispatching
            check_val("disp_rs1_val", disp_rs1_val, fld[7]);
            check_val("disp_rs1_tag", 32'(disp_rs1_tag), fld[8]);
            check_val("disp_rs2_val", disp_rs2_val, fld[9]);
            check_val("disp_rs2_tag", 32'(disp_rs2_tag), fld[10]);
            check_val("disp_rd", 32'(disp_rd), fld[11]);
            check_val("disp_op", 32'(disp_op), fld[12]);
            check_val("disp_imm", disp_imm, fld[13]);
            check_val("disp_pc", disp_pc, fld[14]);
            check_val("disp_tag", 32'(disp_tag), fld[15]);
        end
        check_val("commit_en", 32'(commit_en), fld[17]);
        if (fld[17][0]) begin
            check_val("commit_rd", 32'(commit_rd), fld[18]);
            check_val("commit_data", commit_data, fld[19]);
        end
    endtask

    task automatic wait_issue(output bit timed_out);
        int cycles;
        cycles = 0;
        while (!issue_rdy && cycles < 16) begin
            inst_en = 1'b0;
            wb_en   = 1'b0;
            clr     = 1'b0;
            @(negedge clk);
            cycles++;
        end
        timed_out = !issue_rdy;
    endtask

    initial begin
        string line;
        int    fd;
        int    n;
        int    lnum;
        bit    timed_out;
        rst     = 1'b1;
        clr     = 1'b0;
        inst_en = 1'b0;
        inst    = '0;
        wb_en   = 1'b0;
        wb_tag  = '0;
        wb_data = '0;
        lnum    = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("testbench/rename_stimulus.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open testbench/rename_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                lnum++;
                if (line.len() < 2 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                            fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
                if (n != 20) begin
                    failures++;
                    $display("Stimulus line %0d holds %0d fields instead of 20", lnum, n);
                    continue;
                end
                @(negedge clk);
                if (fld[0][0]) begin
                    wait_issue(timed_out);
                    if (timed_out) begin
                        failures++;
                        $display("issue_rdy stayed low too long before line %0d", lnum);
                        break;
                    end
                end
                inst_en = fld[0][0];
                inst    = fld[1];
                wb_en   = fld[2][0];
                wb_tag  = fld[3][3:0];
                wb_data = fld[4];
                clr     = fld[5][0];
                #3;  // Just before the next rising edge
                compare_outputs();
            end
            $fclose(fd);
        end
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rename_core_sva.sv */
`default_nettype none

module rename_core_sva (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             clr,
    input wire logic             inst_en,
    input wire logic             issue_rdy,
    input wire logic             disp_en,
    input wire rename_pkg::tag_t disp_tag,
    input wire logic             commit_en
);

    rename_pkg::tag_t next_tag;  // Tag the next dispatch has to carry

    always_ff @(posedge clk) begin
        if (rst || clr)
            next_tag <= 4'd1;
        else if (disp_en)
            next_tag <= (next_tag == rename_pkg::tag_t'(rename_pkg::rob_depth)) ?
                        4'd1 : next_tag + 4'd1;
    end

    // A word offered while the ROB is full would be lost
    inst_while_full: assert property (@(posedge clk) disable iff (rst)
        !(inst_en && !issue_rdy))
        else $error("inst_en high while issue_rdy low");

    commit_after_reset: assert property (@(posedge clk) $fell(rst) |-> !commit_en)
        else $error("commit_en in the first cycle after reset");

    // Tags run 1..8 in dispatch order and never read 0 while dispatching
    disp_tag_order: assert property (@(posedge clk) disable iff (rst)
        disp_en |-> (disp_tag == next_tag))
        else $error("disp_tag is 0 or out of allocation order during a dispatch");

endmodule

bind rename_core rename_core_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .clr       (clr),
    .inst_en   (inst_en),
    .issue_rdy (issue_rdy),
    .disp_en   (disp_en),
    .disp_tag  (disp_tag),
    .commit_en (commit_en)
);

`default_nettype wire

/* rtl/rename_core.sv */
`default_nettype none

module rename_core (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  clr,
    input  wire logic                  inst_en,
    input  wire rename_pkg::inst_t     inst,
    input  wire logic                  wb_en,
    input  wire rename_pkg::tag_t      wb_tag,
    input  wire rename_pkg::data_t     wb_data,
    output logic                       issue_rdy,
    output logic                       disp_en,
    output rename_pkg::data_t          disp_rs1_val,
    output rename_pkg::tag_t           disp_rs1_tag,
    output rename_pkg::data_t          disp_rs2_val,
    output rename_pkg::tag_t           disp_rs2_tag,
    output rename_pkg::reg_name_t      disp_rd,
    output rename_pkg::op_class_t      disp_op,
    output rename_pkg::data_t          disp_imm,
    output rename_pkg::addr_t          disp_pc,
    output rename_pkg::tag_t           disp_tag,
    output logic                       commit_en,
    output rename_pkg::reg_name_t      commit_rd,
    output rename_pkg::data_t          commit_data
);

    logic                  dec_en;
    rename_pkg::reg_name_t dec_rs1;
    rename_pkg::reg_name_t dec_rs2;
    rename_pkg::reg_name_t dec_rd;
    rename_pkg::op_class_t dec_op;
    rename_pkg::data_t     dec_imm;
    rename_pkg::addr_t     dec_pc;

    logic                  commit_wr;
    rename_pkg::tag_t      commit_tag;

    inst_decoder u_decoder (
        .clk     (clk),
        .rst     (rst),
        .clr     (clr),
        .rdy     (issue_rdy),
        .inst_en (inst_en),
        .inst    (inst),
        .dec_en  (dec_en),
        .dec_rs1 (dec_rs1),
        .dec_rs2 (dec_rs2),
        .dec_rd  (dec_rd),
        .dec_op  (dec_op),
        .dec_imm (dec_imm),
        .dec_pc  (dec_pc)
    );

    tag_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .clr          (clr),
        .rdy          (issue_rdy),
        .dec_en       (dec_en),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_rd       (dec_rd),
        .dec_op       (dec_op),
        .dec_imm      (dec_imm),
        .dec_pc       (dec_pc),
        .alloc_tag    (disp_tag),
        .commit_en    (commit_en),
        .commit_wr    (commit_wr),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .disp_en      (disp_en),
        .disp_rs1_val (disp_rs1_val),
        .disp_rs2_val (disp_rs2_val),
        .disp_rs1_tag (disp_rs1_tag),
        .disp_rs2_tag (disp_rs2_tag),
        .disp_rd      (disp_rd),
        .disp_op      (disp_op),
        .disp_imm     (disp_imm),
        .disp_pc      (disp_pc)
    );

    reorder_buffer u_rob (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .disp_en     (disp_en),
        .disp_op     (disp_op),
        .disp_rd     (disp_rd),
        .wb_en       (wb_en),
        .wb_tag      (wb_tag),
        .wb_data     (wb_data),
        .rdy         (issue_rdy),
        .alloc_tag   (disp_tag),   // Tag of the instruction dispatching this cycle
        .commit_en   (commit_en),
        .commit_wr   (commit_wr),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .commit_tag  (commit_tag)
    );

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`default_nettype none

module reorder_buffer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  clr,
    input  wire logic                  disp_en,
    input  wire rename_pkg::op_class_t disp_op,
    input  wire rename_pkg::reg_name_t disp_rd,
    input  wire logic                  wb_en,
    input  wire rename_pkg::tag_t      wb_tag,
    input  wire rename_pkg::data_t     wb_data,
    output logic                       rdy,
    output rename_pkg::tag_t           alloc_tag,
    output logic                       commit_en,
    output logic                       commit_wr,
    output rename_pkg::reg_name_t      commit_rd,
    output rename_pkg::data_t          commit_data,
    output rename_pkg::tag_t           commit_tag
);

    logic                  ent_done [rename_pkg::rob_depth];
    logic                  ent_wr   [rename_pkg::rob_depth];
    rename_pkg::reg_name_t ent_rd   [rename_pkg::rob_depth];
    rename_pkg::data_t     ent_data [rename_pkg::rob_depth];

    rename_pkg::rob_idx_t head;
    rename_pkg::rob_idx_t tail;
    rename_pkg::rob_cnt_t count;
    rename_pkg::rob_idx_t wb_idx;

    // Slot n is known outside as tag n+1
    assign alloc_tag  = {1'b0, tail} + 4'd1;
    assign commit_tag = {1'b0, head} + 4'd1;
    assign wb_idx     = rename_pkg::rob_idx_t'(wb_tag - 4'd1);

    assign rdy = (count != rename_pkg::rob_cnt_t'(rename_pkg::rob_depth));

    assign commit_en   = (count != '0) && ent_done[head];
    assign commit_wr   = ent_wr[head];
    assign commit_rd   = ent_rd[head];
    assign commit_data = ent_data[head];

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rename_pkg::rob_depth; i++)
                ent_done[i] <= 1'b0;
        end else begin
            if (disp_en) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 3'd1;
            end
            if (wb_en && (wb_tag != '0))
                ent_done[wb_idx] <= 1'b1;
            if (commit_en)
                head <= head + 3'd1;
            case ({disp_en, commit_en})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: ;  // Both or neither leave occupancy unchanged
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (disp_en) begin
            ent_wr[tail] <= (disp_op != rename_pkg::op_store) &&
                            (disp_op != rename_pkg::op_branch);
            ent_rd[tail] <= disp_rd;
        end
        if (wb_en && (wb_tag != '0))
            ent_data[wb_idx] <= wb_data;
    end

endmodule

`default_nettype wire

/* rtl/tag_regfile.sv */
`default_nettype none

module tag_regfile (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  clr,
    input  wire logic                  rdy,
    input  wire logic                  dec_en,
    input  wire rename_pkg::reg_name_t dec_rs1,
    input  wire rename_pkg::reg_name_t dec_rs2,
    input  wire rename_pkg::reg_name_t dec_rd,
    input  wire rename_pkg::op_class_t dec_op,
    input  wire rename_pkg::data_t     dec_imm,
    input  wire rename_pkg::addr_t     dec_pc,
    input  wire rename_pkg::tag_t      alloc_tag,
    input  wire logic                  commit_en,
    input  wire logic                  commit_wr,
    input  wire rename_pkg::reg_name_t commit_rd,
    input  wire rename_pkg::data_t     commit_data,
    input  wire rename_pkg::tag_t      commit_tag,
    output logic                       disp_en,
    output rename_pkg::data_t          disp_rs1_val,
    output rename_pkg::data_t          disp_rs2_val,
    output rename_pkg::tag_t           disp_rs1_tag,
    output rename_pkg::tag_t           disp_rs2_tag,
    output rename_pkg::reg_name_t      disp_rd,
    output rename_pkg::op_class_t      disp_op,
    output rename_pkg::data_t          disp_imm,
    output rename_pkg::addr_t          disp_pc
);

    rename_pkg::data_t reg_val [rename_pkg::reg_count];
    rename_pkg::tag_t  reg_tag [rename_pkg::reg_count];

    logic rd_renamed;  // Dispatched instruction claims its destination
    logic commit_hit;  // Retiring writer is still the newest one for its register

    assign disp_en = dec_en && rdy && !clr;

    // Operand read sees the state before this edge
    assign disp_rs1_val = (dec_rs1 == '0) ? '0 : reg_val[dec_rs1];
    assign disp_rs2_val = (dec_rs2 == '0) ? '0 : reg_val[dec_rs2];
    assign disp_rs1_tag = (dec_rs1 == '0) ? '0 : reg_tag[dec_rs1];
    assign disp_rs2_tag = (dec_rs2 == '0) ? '0 : reg_tag[dec_rs2];

    assign disp_rd  = dec_rd;
    assign disp_op  = dec_op;
    assign disp_imm = dec_imm;
    assign disp_pc  = dec_pc;

    assign rd_renamed = disp_en && (dec_rd != '0) &&
                        (dec_op != rename_pkg::op_store) &&
                        (dec_op != rename_pkg::op_branch);

    assign commit_hit = commit_en && commit_wr && (commit_rd != '0) &&
                        (reg_tag[commit_rd] == commit_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::reg_count; i++) begin
                reg_val[i] <= '0;
                reg_tag[i] <= '0;
            end
        end else begin
            // Retirement still lands during a flush
            if (commit_en && commit_wr && (commit_rd != '0))
                reg_val[commit_rd] <= commit_data;
            if (clr) begin
                for (int i = 0; i < rename_pkg::reg_count; i++)
                    reg_tag[i] <= '0;
            end else begin
                if (commit_hit)
                    reg_tag[commit_rd] <= '0;
                if (rd_renamed)
                    reg_tag[dec_rd] <= alloc_tag;  // Newer writer overrides the clear
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 clr,
    input  wire logic                 rdy,
    input  wire logic                 inst_en,
    input  wire rename_pkg::inst_t    inst,
    output logic                      dec_en,
    output rename_pkg::reg_name_t     dec_rs1,
    output rename_pkg::reg_name_t     dec_rs2,
    output rename_pkg::reg_name_t     dec_rd,
    output rename_pkg::op_class_t     dec_op,
    output rename_pkg::data_t         dec_imm,
    output rename_pkg::addr_t         dec_pc
);

    rename_pkg::addr_t     pc_cnt;    // pc of the next accepted instruction
    rename_pkg::op_class_t op_next;
    rename_pkg::data_t     imm_next;

    always_comb begin
        op_next  = rename_pkg::op_alu;
        imm_next = '0;
        case (inst[6:0])
            rename_pkg::opc_lui: begin
                op_next  = rename_pkg::op_lui;
                imm_next = {inst[31:12], 12'b0};
            end
            rename_pkg::opc_auipc: begin
                imm_next = {inst[31:12], 12'b0};
            end
            rename_pkg::opc_jal: begin
                op_next  = rename_pkg::op_jal;
                imm_next = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rename_pkg::opc_jalr: begin
                op_next  = rename_pkg::op_jal;
                imm_next = {{20{inst[31]}}, inst[31:20]};
            end
            rename_pkg::opc_branch: begin
                op_next  = rename_pkg::op_branch;
                imm_next = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rename_pkg::opc_load: begin
                op_next  = rename_pkg::op_load;
                imm_next = {{20{inst[31]}}, inst[31:20]};
            end
            rename_pkg::opc_store: begin
                op_next  = rename_pkg::op_store;
                imm_next = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rename_pkg::opc_op_imm: begin
                imm_next = {{20{inst[31]}}, inst[31:20]};
            end
            default: ;  // Register-register ALU, no immediate
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            dec_en  <= 1'b0;
            dec_rs1 <= '0;
            dec_rs2 <= '0;
            dec_rd  <= '0;
            dec_op  <= rename_pkg::op_alu;
            dec_imm <= '0;
            dec_pc  <= '0;
            pc_cnt  <= '0;
        end else if (rdy) begin  // Hold everything while stalled
            dec_en <= inst_en;
            if (inst_en) begin
                dec_rs1 <= inst[19:15];
                dec_rs2 <= inst[24:20];
                dec_rd  <= inst[11:7];
                dec_op  <= op_next;
                dec_imm <= imm_next;
                dec_pc  <= pc_cnt;
                pc_cnt  <= pc_cnt + rename_pkg::pc_step;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int rob_depth = 8;
    localparam int reg_count = 32;

    typedef logic [4:0]  reg_name_t;  // Architectural register name
    typedef logic [31:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  tag_t;       // 0 = value in register file, 1..8 = ROB slot + 1
    typedef logic [2:0]  rob_idx_t;   // ROB slot pointer
    typedef logic [3:0]  rob_cnt_t;   // Occupancy, 0..rob_depth
    typedef logic [6:0]  opcode_t;

    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_lui    = 3'd1,
        op_load   = 3'd2,
        op_store  = 3'd3,
        op_branch = 3'd4,
        op_jal    = 3'd5
    } op_class_t;

    // RV32I major opcodes
    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_auipc  = 7'b0010111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_load   = 7'b0000011;
    localparam opcode_t opc_store  = 7'b0100011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_op     = 7'b0110011;

    localparam addr_t pc_step = 32'd4;

endpackage

`default_nettype wire
